// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_gmii_to_axis
RTL_TOP    := gmii_to_axis
FILELIST   := filelist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_gmii_to_axis.sv
// Testbench for the GMII to AXI-Stream bridge
// Receive, error, back-pressure, transmit and loopback tests
`timescale 1ns/100ps
`default_nettype none

module tb_gmii_to_axis
  import gmii_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;  // Cycles

  typedef byte_t bytes_t[$];

  logic        clk125;
  logic        arst_n;
  logic        loopback;
  logic        drv_rx_dv;
  logic        drv_rx_er;
  byte_t       drv_rxd;
  logic        rx_dv;
  logic        rx_er;
  byte_t       rxd;
  logic        gtx_clk;
  logic        tx_en;
  logic        tx_er;
  byte_t       txd;
  word_t       rx_tdata;
  tuser_t      rx_tuser;
  logic        rx_tlast;
  logic        rx_tvalid;
  logic        rx_tready;
  word_t       tx_tdata;
  tuser_t      tx_tuser;
  logic        tx_tlast;
  logic        tx_tvalid;
  logic        tx_tready;
  logic [15:0] lfsr;
  int          gap = 1000;  // Low cycles of tx_en since the last frame

  // Loopback turns the transmit side back into the receiver
  assign rx_dv = loopback ? tx_en : drv_rx_dv;
  assign rx_er = loopback ? tx_er : drv_rx_er;
  assign rxd   = loopback ? txd : drv_rxd;

  gmii_to_axis #(
    .RX_FIFO_WORDS (32)
  ) u_gmii_to_axis (
    .clk125       (clk125),
    .arst_n       (arst_n),
    .gmii_gtx_clk (gtx_clk),
    .gmii_tx_en   (tx_en),
    .gmii_tx_er   (tx_er),
    .gmii_txd     (txd),
    .gmii_rx_dv   (rx_dv),
    .gmii_rx_er   (rx_er),
    .gmii_rxd     (rxd),
    .rx_tdata     (rx_tdata),
    .rx_tuser     (rx_tuser),
    .rx_tlast     (rx_tlast),
    .rx_tvalid    (rx_tvalid),
    .rx_tready    (rx_tready),
    .tx_tdata     (tx_tdata),
    .tx_tuser     (tx_tuser),
    .tx_tlast     (tx_tlast),
    .tx_tvalid    (tx_tvalid),
    .tx_tready    (tx_tready)
  );

  initial begin
    clk125 = 1'b0;
    forever #50 clk125 = ~clk125;
  end

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_word(input string test, input string what,
                              input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: %s expected %h actual %h", test, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_tuser(input string test, input string what,
                               input tuser_t expected, input tuser_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: %s expected %h actual %h", test, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_byte(input string test, input string what,
                              input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: %s expected %h actual %h", test, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_flag(input string test, input string what,
                              input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: %s expected %b actual %b", test, what, expected, actual);
      abort_run();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_byte(output byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  task automatic rand_len(input int lo, input int hi, output int len);
    byte_t b;
    rand_byte(b);
    len = lo + int'(b) % (hi - lo + 1);
  endtask

  task automatic make_payload(input int len, output bytes_t data);
    byte_t b;
    data = {};
    for (int i = 0; i < len; i++) begin
      rand_byte(b);
      data.push_back(b);
    end
  endtask

  // Preamble, SFD, payload padded to the minimum, FCS least significant byte first
  function automatic bytes_t wire_frame(bytes_t payload);
    bytes_t f;
    crc_t   crc;
    byte_t  b;
    crc = CRC_INIT;
    for (int i = 0; i < 7; i++) begin
      f.push_back(PREAMBLE_BYTE);
    end
    f.push_back(SFD_BYTE);
    for (int i = 0; i < payload.size() || i < MIN_PAYLOAD; i++) begin
      b   = (i < payload.size()) ? payload[i] : 8'h00;
      crc = crc32_step(crc, b);
      f.push_back(b);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
      f.push_back(crc[8*i +: 8]);
    end
    return f;
  endfunction

  task automatic send_gmii(input bytes_t f, input int er_at);
    for (int i = 0; i < f.size(); i++) begin
      drv_rx_dv = 1'b1;
      drv_rxd   = f[i];
      drv_rx_er = (i == er_at);
      @(negedge clk125);
    end
    drv_rx_dv = 1'b0;
    drv_rxd   = '0;
    drv_rx_er = 1'b0;
    repeat (IFG_CYCLES) @(negedge clk125);
  endtask

  task automatic read_frame(input string name, input bytes_t payload, input logic err);
    int    nwords;
    int    k;
    int    timer;
    word_t expected;
    word_t mask;
    nwords    = (payload.size() + 7) / 8;
    k         = 0;
    timer     = 0;
    rx_tready = 1'b1;
    while (k < nwords) begin
      if (rx_tvalid) begin
        expected = '0;
        mask     = '0;
        for (int j = 0; j < 8; j++) begin
          if (8*k + j < payload.size()) begin
            expected[8*j +: 8] = payload[8*k + j];
            mask[8*j +: 8]     = 8'hFF;
          end
        end
        compare_word(name, $sformatf("tdata of word %0d", k), expected, rx_tdata & mask);
        compare_flag(name, $sformatf("tlast of word %0d", k), k == nwords - 1, rx_tlast);
        if (k == nwords - 1) begin
          compare_tuser(name, "tuser", tuser_t'({err, 3'(payload.size() % 8)}), rx_tuser);
        end
        k++;
        timer = 0;
      end else if (timer == WAIT_LIMIT) begin
        $display("Timeout in %s: the receive stream stopped after %0d of %0d words",
                 name, k, nwords);
        abort_run();
      end else begin
        timer++;
      end
      @(negedge clk125);
    end
    rx_tready = 1'b0;
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      if (rx_tvalid) begin
        $display("%s: a frame came out of the receive FIFO that should have been dropped",
                 name);
        abort_run();
      end
      @(negedge clk125);
    end
  endtask

  task automatic send_stream(input bytes_t payload);
    int nwords;
    int timer;
    nwords = (payload.size() + 7) / 8;
    for (int k = 0; k < nwords; k++) begin
      tx_tdata = '0;
      for (int j = 0; j < 8; j++) begin
        if (8*k + j < payload.size()) begin
          tx_tdata[8*j +: 8] = payload[8*k + j];
        end
      end
      tx_tlast  = (k == nwords - 1);
      tx_tuser  = tx_tlast ? tuser_t'(payload.size() % 8) : '0;
      tx_tvalid = 1'b1;
      timer     = 0;
      while (!tx_tready) begin
        if (timer == WAIT_LIMIT) begin
          $display("Timeout: the transmit stream never took word %0d", k);
          abort_run();
        end
        timer++;
        @(negedge clk125);
      end
      @(negedge clk125);  // Accepted on the rising edge in between
    end
    tx_tvalid = 1'b0;
    tx_tlast  = 1'b0;
    tx_tdata  = '0;
    tx_tuser  = '0;
  endtask

  task automatic capture_gmii(input string name, input bytes_t expected);
    bytes_t got;
    int     timer;
    timer = 0;
    while (!tx_en) begin
      if (timer == WAIT_LIMIT) begin
        $display("Timeout in %s: gmii_tx_en never rose", name);
        abort_run();
      end
      timer++;
      @(negedge clk125);
    end
    while (tx_en) begin
      got.push_back(txd);
      if (got.size() > expected.size() + 8) begin
        $display("%s: the GMII frame does not end", name);
        abort_run();
      end
      @(negedge clk125);
    end
    if (got.size() != expected.size()) begin
      $display("[FAIL] %s: frame length expected %0d actual %0d",
               name, expected.size(), got.size());
      abort_run();
    end
    for (int i = 0; i < got.size(); i++) begin
      compare_byte(name, $sformatf("byte %0d", i), expected[i], got[i]);
    end
  endtask

  // Transmit side watch, runs through every test
  always @(negedge clk125) begin
    if (arst_n) begin
      if (tx_er) begin
        $display("gmii_tx_er was raised on the transmit side");
        abort_run();
      end
      if (tx_en) begin
        if (gap > 0 && gap < IFG_CYCLES) begin
          $display("Interframe gap of only %0d cycles before a frame", gap);
          abort_run();
        end
        gap = 0;
      end else if (gap < 1000) begin
        gap++;
      end
    end
  end

  // Forwarded transmit clock follows clk125, sampled mid-phase
  task automatic test_gtx_clk();
    for (int i = 0; i < 4; i++) begin
      #25;
      compare_flag("gtx_clk", "gmii_gtx_clk in the low half", 1'b0, gtx_clk);
      #50;
      compare_flag("gtx_clk", "gmii_gtx_clk in the high half", 1'b1, gtx_clk);
      @(negedge clk125);
    end
  endtask

  task automatic test_rx_good();
    bytes_t pay;
    int     len;
    for (int n = 0; n < 4; n++) begin
      rand_len(60, 100, len);
      make_payload(len, pay);
      send_gmii(wire_frame(pay), -1);
      read_frame("rx_good", pay, 1'b0);
    end
  endtask

  task automatic test_rx_errors();
    bytes_t pay;
    bytes_t wf;
    make_payload(64, pay);
    wf = wire_frame(pay);
    wf[wf.size() - 2] = wf[wf.size() - 2] ^ 8'h01;  // Third FCS byte
    send_gmii(wf, -1);
    read_frame("rx_bad_fcs", pay, 1'b1);
    make_payload(71, pay);
    send_gmii(wire_frame(pay), 8 + 10);
    read_frame("rx_er", pay, 1'b1);
  endtask

  task automatic test_rx_backpressure();
    bytes_t frame_a;
    bytes_t frame_b;
    bytes_t big;
    make_payload(64, frame_a);
    make_payload(64, frame_b);
    make_payload(300, big);  // 38 words, more than the FIFO has left
    send_gmii(wire_frame(frame_a), -1);
    send_gmii(wire_frame(frame_b), -1);
    send_gmii(wire_frame(big), -1);
    read_frame("rx_backpressure", frame_a, 1'b0);
    read_frame("rx_backpressure", frame_b, 1'b0);
    expect_quiet("rx_backpressure", 50);
    make_payload(80, big);
    send_gmii(wire_frame(big), -1);
    read_frame("rx_after_drop", big, 1'b0);
  endtask

  task automatic test_tx();
    bytes_t short_pay;
    bytes_t long_pay;
    make_payload(20, short_pay);
    make_payload(70, long_pay);
    fork
      begin
        send_stream(short_pay);
        send_stream(long_pay);
      end
      begin
        capture_gmii("tx_short", wire_frame(short_pay));
        capture_gmii("tx_long", wire_frame(long_pay));
      end
    join
  endtask

  task automatic test_loopback();
    bytes_t pay;
    int     len;
    loopback = 1'b1;
    for (int n = 0; n < 4; n++) begin
      rand_len(60, 120, len);
      make_payload(len, pay);
      send_stream(pay);
      read_frame("loopback", pay, 1'b0);
    end
    loopback = 1'b0;
  endtask

  initial begin : main
    lfsr      = 16'd64759;
    loopback  = 1'b0;
    drv_rx_dv = 1'b0;
    drv_rx_er = 1'b0;
    drv_rxd   = '0;
    rx_tready = 1'b0;
    tx_tdata  = '0;
    tx_tuser  = '0;
    tx_tlast  = 1'b0;
    tx_tvalid = 1'b0;
    arst_n    = 1'b0;
    repeat (10) @(negedge clk125);
    if (tx_en || tx_er || rx_tvalid || tx_tready) begin
      $display("Outputs are not low during reset");
      abort_run();
    end
    arst_n = 1'b1;
    repeat (2) @(negedge clk125);
    test_gtx_clk();
    test_rx_good();
    test_rx_errors();
    test_rx_backpressure();
    test_tx();
    test_loopback();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
source/gmii_pkg.sv
source/gmii_rx.sv
source/ll8_to_axi64.sv
source/rx_frame_fifo.sv
source/axi64_to_ll8.sv
source/gmii_tx.sv
source/gmii_to_axis.sv
bench/tb_gmii_to_axis.sv

// File: source/axi64_to_ll8.sv
// 64-bit stream to byte link unpacker
// The tlast word ends at the byte count given in tuser
`timescale 1ns/100ps
`default_nettype none

module axi64_to_ll8
  import gmii_pkg::*;
(
  input  wire        clk125,
  input  wire        arst_n,
  input  wire axis_t tx,
  input  wire        tx_tvalid,
  output logic       tx_tready,
  output ll8_t       link,
  output logic       link_src_rdy,
  input  wire        link_dst_rdy
);

  axis_t      held;
  logic       full;
  logic       armed;  // Low for the first cycle out of reset
  logic [2:0] index;
  logic [2:0] last_index;
  logic       last_byte;
  logic       take;
  logic       load;

  assign last_index   = held.tlast ? held.tuser[2:0] - 3'd1 : 3'd7;  // 0 means all 8
  assign last_byte    = (index == last_index);
  assign take         = full && link_dst_rdy;
  assign tx_tready    = armed && (!full || (take && last_byte));  // Refill as the last byte goes
  assign load         = tx_tvalid && tx_tready;
  assign link_src_rdy = full;

  always_comb begin
    link.data  = held.tdata[{index, 3'b000} +: 8];
    link.eof   = held.tlast && last_byte;
    link.error = held.tlast && last_byte && held.tuser[3];
  end

  always_ff @(posedge clk125) begin
    if (load) begin
      held <= tx;
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      armed <= 1'b0;
      full  <= 1'b0;
      index <= '0;
    end else begin
      armed <= 1'b1;
      if (load) begin
        full  <= 1'b1;
        index <= '0;
      end else if (take && last_byte) begin
        full <= 1'b0;
      end else if (take) begin
        index <= index + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/gmii_pkg.sv
// Shared types for the GMII to AXI-Stream bridge
// Byte link and stream structs, frame constants, CRC-32 byte step
`default_nettype none

package gmii_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [63:0] word_t;   // Byte 0 in bits 7..0
  typedef logic [3:0]  tuser_t;  // [3] error, [2:0] bytes in last word, 0 means 8
  typedef logic [31:0] crc_t;

  typedef struct packed {
    byte_t data;
    logic  eof;
    logic  error;  // Valid with eof
  } ll8_t;

  typedef struct packed {
    word_t  tdata;
    tuser_t tuser;
    logic   tlast;
  } axis_t;

  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;

  localparam int MIN_PAYLOAD = 60;  // Frame length before the FCS
  localparam int IFG_CYCLES  = 12;

  localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
  localparam crc_t CRC_POLY    = 32'hEDB8_8320;  // Reflected IEEE 802.3
  localparam crc_t CRC_RESIDUE = 32'hDEBB_20E3;  // Register after a good FCS

  // One byte of the reflected CRC-32, LSB first, no final inversion
  function automatic crc_t crc32_step(crc_t crc, byte_t data);
    crc_t c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// File: source/gmii_rx.sv
// Receive MAC: preamble and SFD detection, FCS check and strip
// Payload leaves on a byte link that cannot stall
`timescale 1ns/100ps
`default_nettype none

module gmii_rx
  import gmii_pkg::*;
(
  input  wire        clk125,
  input  wire        arst_n,
  input  wire        gmii_rx_dv,
  input  wire        gmii_rx_er,
  input  wire byte_t gmii_rxd,
  output ll8_t       link,
  output logic       link_valid
);

  typedef enum logic [1:0] {
    IDLE,
    PREAMBLE,
    DATA,
    DROP
  } rx_state_t;

  rx_state_t   state;
  byte_t [3:0] delay;      // Newest four bytes, may still be the FCS
  byte_t       hold;       // Oldest byte, known to be payload
  logic        hold_valid;
  logic [2:0]  fill;
  crc_t        crc;
  logic        err_seen;
  logic        sfd_seen;
  logic        shift;

  assign sfd_seen = gmii_rx_dv && (gmii_rxd == SFD_BYTE) &&
                    (state == IDLE || state == PREAMBLE);
  assign shift    = (state == DATA) && gmii_rx_dv;

  always_ff @(posedge clk125) begin
    if (shift) begin
      delay <= {delay[2:0], gmii_rxd};
      if (fill == 3'd4) begin
        hold <= delay[3];
      end
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      fill       <= '0;
      hold_valid <= 1'b0;
      crc        <= CRC_INIT;
      err_seen   <= 1'b0;
      link       <= '0;
      link_valid <= 1'b0;
    end else begin
      link_valid <= 1'b0;
      link.eof   <= 1'b0;
      link.error <= 1'b0;
      if (sfd_seen) begin
        state      <= DATA;
        fill       <= '0;
        hold_valid <= 1'b0;
        crc        <= CRC_INIT;
        err_seen   <= 1'b0;
      end else begin
        case (state)
          IDLE: begin
            if (gmii_rx_dv) begin
              state <= (gmii_rxd == PREAMBLE_BYTE) ? PREAMBLE : DROP;
            end
          end
          PREAMBLE: begin
            if (!gmii_rx_dv) begin
              state <= IDLE;
            end else if (gmii_rxd != PREAMBLE_BYTE) begin
              state <= DROP;
            end
          end
          DATA: begin
            if (gmii_rx_dv) begin
              crc      <= crc32_step(crc, gmii_rxd);
              err_seen <= err_seen | gmii_rx_er;
              if (fill != 3'd4) begin
                fill <= fill + 3'd1;
              end else begin
                hold_valid <= 1'b1;
              end
              if (hold_valid) begin
                link.data  <= hold;
                link_valid <= 1'b1;
              end
            end else begin
              // End of carrier, the delay line now holds the FCS
              state <= IDLE;
              if (hold_valid) begin
                link.data  <= hold;
                link.eof   <= 1'b1;
                link.error <= err_seen | (crc != CRC_RESIDUE);
                link_valid <= 1'b1;
              end
            end
          end
          default: begin
            if (!gmii_rx_dv) begin
              state <= IDLE;
            end
          end
        endcase
      end
    end
  end

  // A frame leaves on the link without gaps up to its eof
  a_no_gap_before_eof: assert property (@(posedge clk125) disable iff (!arst_n)
    link_valid && !link.eof |=> link_valid);

endmodule

`default_nettype wire

// File: source/gmii_to_axis.sv
// GMII to 64-bit AXI-Stream bridge top level
// Receive chain MAC, packer, frame FIFO; transmit chain unpacker, MAC
`timescale 1ns/100ps
`default_nettype none

module gmii_to_axis
  import gmii_pkg::*;
#(
  parameter int RX_FIFO_WORDS = 32
)(
  input  wire         clk125,
  input  wire         arst_n,

  // GMII
  output logic        gmii_gtx_clk,
  output logic        gmii_tx_en,
  output logic        gmii_tx_er,
  output byte_t       gmii_txd,
  input  wire         gmii_rx_dv,
  input  wire         gmii_rx_er,
  input  wire byte_t  gmii_rxd,

  // Client streams
  output word_t       rx_tdata,
  output tuser_t      rx_tuser,
  output logic        rx_tlast,
  output logic        rx_tvalid,
  input  wire         rx_tready,
  input  wire word_t  tx_tdata,
  input  wire tuser_t tx_tuser,
  input  wire         tx_tlast,
  input  wire         tx_tvalid,
  output logic        tx_tready
);

  ll8_t  rx_link;
  logic  rx_link_valid;
  axis_t rx_word;
  logic  rx_word_valid;
  axis_t rx_out;
  axis_t tx_in;
  ll8_t  tx_link;
  logic  tx_link_src_rdy;
  logic  tx_link_dst_rdy;

  assign gmii_gtx_clk = clk125;  // Transmit runs on the same 125 MHz clock

  assign tx_in    = '{tdata: tx_tdata, tuser: tx_tuser, tlast: tx_tlast};
  assign rx_tdata = rx_out.tdata;
  assign rx_tuser = rx_out.tuser;
  assign rx_tlast = rx_out.tlast;

  gmii_rx u_gmii_rx (
    .clk125     (clk125),
    .arst_n     (arst_n),
    .gmii_rx_dv (gmii_rx_dv),
    .gmii_rx_er (gmii_rx_er),
    .gmii_rxd   (gmii_rxd),
    .link       (rx_link),
    .link_valid (rx_link_valid)
  );

  ll8_to_axi64 u_ll8_to_axi64 (
    .clk125     (clk125),
    .arst_n     (arst_n),
    .link       (rx_link),
    .link_valid (rx_link_valid),
    .word       (rx_word),
    .word_valid (rx_word_valid)
  );

  rx_frame_fifo #(
    .RX_FIFO_WORDS (RX_FIFO_WORDS)
  ) u_rx_frame_fifo (
    .clk125     (clk125),
    .arst_n     (arst_n),
    .word       (rx_word),
    .word_valid (rx_word_valid),
    .rx         (rx_out),
    .rx_tvalid  (rx_tvalid),
    .rx_tready  (rx_tready)
  );

  axi64_to_ll8 u_axi64_to_ll8 (
    .clk125       (clk125),
    .arst_n       (arst_n),
    .tx           (tx_in),
    .tx_tvalid    (tx_tvalid),
    .tx_tready    (tx_tready),
    .link         (tx_link),
    .link_src_rdy (tx_link_src_rdy),
    .link_dst_rdy (tx_link_dst_rdy)
  );

  gmii_tx u_gmii_tx (
    .clk125       (clk125),
    .arst_n       (arst_n),
    .link         (tx_link),
    .link_src_rdy (tx_link_src_rdy),
    .link_dst_rdy (tx_link_dst_rdy),
    .gmii_tx_en   (gmii_tx_en),
    .gmii_tx_er   (gmii_tx_er),
    .gmii_txd     (gmii_txd)
  );

endmodule

`default_nettype wire

// File: source/gmii_tx.sv
// Transmit MAC: preamble, payload, zero padding, FCS
// Interframe gap is held after every frame
`timescale 1ns/100ps
`default_nettype none

module gmii_tx
  import gmii_pkg::*;
(
  input  wire       clk125,
  input  wire       arst_n,
  input  wire ll8_t link,
  input  wire       link_src_rdy,
  output logic      link_dst_rdy,
  output logic      gmii_tx_en,
  output logic      gmii_tx_er,
  output byte_t     gmii_txd
);

  typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,
    DATA,
    PAD,
    FCS,
    GAP
  } tx_state_t;

  tx_state_t  state;
  logic [3:0] count;   // Preamble, FCS and gap position
  logic [5:0] length;  // Payload bytes sent, saturates at the minimum
  crc_t       crc;
  crc_t       fcs;

  assign link_dst_rdy = (state == DATA);
  assign fcs          = ~crc;

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      count      <= '0;
      length     <= '0;
      crc        <= CRC_INIT;
      gmii_tx_en <= 1'b0;
      gmii_tx_er <= 1'b0;
      gmii_txd   <= '0;
    end else begin
      gmii_tx_er <= 1'b0;
      case (state)
        IDLE: begin
          gmii_tx_en <= 1'b0;
          if (link_src_rdy) begin
            gmii_tx_en <= 1'b1;
            gmii_txd   <= PREAMBLE_BYTE;
            count      <= 4'd1;
            state      <= PREAMBLE;
          end
        end
        PREAMBLE: begin
          count <= count + 4'd1;
          if (count == 4'd7) begin
            gmii_txd <= SFD_BYTE;
            crc      <= CRC_INIT;
            length   <= '0;
            state    <= DATA;
          end else begin
            gmii_txd <= PREAMBLE_BYTE;
          end
        end
        DATA: begin
          if (link_src_rdy) begin
            gmii_txd <= link.data;
            crc      <= crc32_step(crc, link.data);
            if (length != 6'(MIN_PAYLOAD)) begin
              length <= length + 6'd1;
            end
            if (link.eof) begin
              gmii_tx_er <= link.error;
              count      <= '0;
              state      <= (length < 6'(MIN_PAYLOAD - 1)) ? PAD : FCS;
            end
          end else begin
            gmii_txd   <= '0;
            gmii_tx_er <= 1'b1;  // Underrun, frame is corrupted
          end
        end
        PAD: begin
          gmii_txd <= '0;
          crc      <= crc32_step(crc, 8'h00);
          length   <= length + 6'd1;
          if (length == 6'(MIN_PAYLOAD - 1)) begin
            state <= FCS;
          end
        end
        FCS: begin
          gmii_txd <= fcs[{count[1:0], 3'b000} +: 8];  // LSB first
          count    <= count + 4'd1;
          if (count == 4'd3) begin
            count <= '0;
            state <= GAP;
          end
        end
        default: begin
          gmii_tx_en <= 1'b0;
          count      <= count + 4'd1;
          if (count == 4'(IFG_CYCLES - 1)) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  a_ifg: assert property (@(posedge clk125) disable iff (!arst_n)
    $fell(gmii_tx_en) |-> (!gmii_tx_en) [*IFG_CYCLES]);

endmodule

`default_nettype wire

// File: source/ll8_to_axi64.sv
// Byte link to 64-bit stream packer
// Occupancy and frame error go out in tuser on the last word
`timescale 1ns/100ps
`default_nettype none

module ll8_to_axi64
  import gmii_pkg::*;
(
  input  wire       clk125,
  input  wire       arst_n,
  input  wire ll8_t link,
  input  wire       link_valid,
  output axis_t     word,
  output logic      word_valid
);

  word_t      lanes;
  word_t      lanes_next;
  logic [2:0] count;  // Next lane to fill
  logic       emit;

  assign emit = link_valid && (link.eof || count == 3'd7);

  always_comb begin
    lanes_next = lanes;
    lanes_next[{count, 3'b000} +: 8] = link.data;
  end

  always_ff @(posedge clk125) begin
    if (link_valid) begin
      lanes <= emit ? '0 : lanes_next;  // Unused lanes of a short word stay zero
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      count      <= '0;
      word       <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= emit;
      if (link_valid) begin
        count <= emit ? 3'd0 : count + 3'd1;
      end
      if (emit) begin
        word.tdata <= lanes_next;
        word.tuser <= {link.eof & link.error, count + 3'd1};  // Eight wraps to 0
        word.tlast <= link.eof;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rx_frame_fifo.sv
// Receive word FIFO with whole-frame commit
// A frame that overflows is dropped, committed frames are kept
`timescale 1ns/100ps
`default_nettype none

module rx_frame_fifo
  import gmii_pkg::*;
#(
  parameter int RX_FIFO_WORDS = 32
)(
  input  wire        clk125,
  input  wire        arst_n,
  input  wire axis_t word,
  input  wire        word_valid,
  output axis_t      rx,
  output logic       rx_tvalid,
  input  wire        rx_tready
);

  localparam int AW = $clog2(RX_FIFO_WORDS);

  typedef logic [AW:0] ptr_t;  // One extra bit tells full from empty

  localparam ptr_t DEPTH = ptr_t'(RX_FIFO_WORDS);

  axis_t mem [RX_FIFO_WORDS];
  ptr_t  wr_ptr;
  ptr_t  commit_ptr;
  ptr_t  rd_ptr;
  ptr_t  used;
  logic  full;
  logic  dropping;  // Rest of an overflowed frame is discarded
  logic  write;

  assign used  = wr_ptr - rd_ptr;
  assign full  = (used == DEPTH);
  assign write = word_valid && !dropping && !full;

  always_ff @(posedge clk125) begin
    if (write) begin
      mem[wr_ptr[AW-1:0]] <= word;
    end
  end

  always_ff @(posedge clk125 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      rd_ptr     <= '0;
      dropping   <= 1'b0;
    end else begin
      if (rx_tvalid && rx_tready) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      if (write) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
        if (word.tlast) begin
          commit_ptr <= wr_ptr + ptr_t'(1);
        end
      end else if (word_valid && dropping) begin
        if (word.tlast) begin
          dropping <= 1'b0;
        end
      end else if (word_valid) begin
        // No room left, rewind over the partial frame
        wr_ptr   <= commit_ptr;
        dropping <= !word.tlast;
      end
    end
  end

  // Only committed frames are visible to the client
  assign rx        = mem[rd_ptr[AW-1:0]];
  assign rx_tvalid = (rd_ptr != commit_ptr);

  a_read_behind_commit: assert property (@(posedge clk125) disable iff (!arst_n)
    ptr_t'(commit_ptr - rd_ptr) <= DEPTH);

endmodule

`default_nettype wire
